/* hdl/cpu_pkg.sv */
package cpu_pkg;

    localparam int imm_w = 17;                 // width of the i-type immediate field

    typedef logic [31:0] word_t;               // data or address word
    typedef logic [4:0]  reg_addr_t;           // register number

    // major opcode in bits 31..27
    typedef enum logic [4:0] {
        op_rtype = 5'd0,
        op_j     = 5'd1,
        op_bne   = 5'd2,
        op_addi  = 5'd5,
        op_blt   = 5'd6,
        op_sw    = 5'd7,
        op_lw    = 5'd8
    } opcode_e;

    // alu function field of r-type words
    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;                    // 31..27
        reg_addr_t  rd;                        // 26..22
        reg_addr_t  rs;                        // 21..17
        reg_addr_t  rt;                        // 16..12
        logic [4:0] shamt;                     // 11..7
        alu_op_e    alu_op;                    // 6..2
        logic [1:0] spare;
    } insn_t;

    localparam insn_t nop_insn = '0;           // add r0 = r0 + r0

    typedef struct packed {
        insn_t insn;
        word_t pc;
    } fd_reg_t;

    typedef struct packed {
        insn_t insn;
        word_t pc;
        word_t a;                              // rs value
        word_t b;                              // rt, or rd for sw and branches
    } dx_reg_t;

    typedef struct packed {
        insn_t insn;
        word_t result;
        word_t store_data;                     // sw data, rides along from operand b
    } xm_reg_t;

    typedef struct packed {
        insn_t insn;
        word_t result;
        word_t mem_data;
    } mw_reg_t;

    // result that decode may bypass from a later stage
    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } fwd_t;

endpackage

/* hdl/alu.sv */
module alu import cpu_pkg::*; (
    input  word_t      a_i,
    input  word_t      b_i,
    input  alu_op_e    op_i,
    input  logic [4:0] shamt_i,
    output word_t      result_o,
    output logic       not_equal_o,
    output logic       less_than_o      // signed a < b
);

    always_comb begin
        case (op_i)
            alu_add: result_o = a_i + b_i;
            alu_sub: result_o = a_i - b_i;
            alu_and: result_o = a_i & b_i;
            alu_or:  result_o = a_i | b_i;
            alu_sll: result_o = a_i << shamt_i;
            alu_sra: result_o = word_t'($signed(a_i) >>> shamt_i);  // sign bit fills in
            default: result_o = '0;                                // unused op codes
        endcase
    end

    // flags for bne / blt, both taken straight off the operands
    assign not_equal_o = (a_i != b_i);
    assign less_than_o = ($signed(a_i) < $signed(b_i));

endmodule

/* hdl/fetch_stage.sv */
module fetch_stage import cpu_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic    clock,
    input  logic    rst_n_i,
    input  word_t   q_imem_i,
    input  logic    branch_taken_i,          // from execute
    input  word_t   branch_target_i,
    output word_t   address_imem_o,
    output fd_reg_t fd_o
);

    word_t   pc_q;
    word_t   pc_d;
    insn_t   fetched;
    logic    is_j;
    word_t   j_target;
    fd_reg_t fd_q;

    assign fetched  = q_imem_i;
    assign is_j     = (fetched.opcode == op_j);       // j is resolved right here
    assign j_target = {5'd0, q_imem_i[26:0]};         // target field zero-extended

    // older redirect wins, a branch in execute beats a j in fetch
    assign pc_d = branch_taken_i ? branch_target_i :
                  is_j           ? j_target        :
                                   pc_q + 32'd1;

    always_ff @(posedge clock) begin
        fd_q.pc <= pc_q;
        if (!rst_n_i) begin
            pc_q      <= reset_pc;
            fd_q.insn <= nop_insn;
        end else begin
            pc_q      <= pc_d;
            fd_q.insn <= (branch_taken_i || is_j) ? nop_insn : fetched;  // squash slot
        end
    end

    assign address_imem_o = pc_q;
    assign fd_o           = fd_q;

    // nothing stalls, so the pc must move on every edge
    a_pc_moves: assert property (@(posedge clock) disable iff (!rst_n_i)
        $past(rst_n_i) |-> pc_q != $past(pc_q));

endmodule

/* hdl/regfile.sv */
module regfile import cpu_pkg::*; (
    input  logic      clock,
    input  logic      rst_n_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    output word_t     rdata_a_o,
    output word_t     rdata_b_o
);

    word_t regs [32];
    logic  wr_live;

    assign wr_live = we_i && (waddr_i != '0);         // r0 never takes a write

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through lets decode see the value committed this cycle
    assign rdata_a_o = (wr_live && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (wr_live && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

    a_r0_zero: assert property (@(posedge clock) disable iff (!rst_n_i)
        (raddr_a_i != '0 || rdata_a_o == '0) && (raddr_b_i != '0 || rdata_b_o == '0));

endmodule

/* hdl/decode_stage.sv */
module decode_stage import cpu_pkg::*; (
    input  logic      clock,
    input  logic      rst_n_i,
    input  fd_reg_t   fd_i,
    input  word_t     rdata_a_i,
    input  word_t     rdata_b_i,
    input  fwd_t      ex_fwd_i,            // result being computed in execute
    input  fwd_t      mem_fwd_i,           // result sitting in the memory stage
    input  logic      branch_taken_i,
    output reg_addr_t raddr_a_o,
    output reg_addr_t raddr_b_o,
    output dx_reg_t   dx_o
);

    insn_t   insn;
    logic    rd_on_b;
    word_t   op_a;
    word_t   op_b;
    dx_reg_t dx_q;

    // youngest producer first, then memory stage, then the register file
    function automatic word_t fwd_pick(input reg_addr_t addr, input word_t rf_data,
                                       input fwd_t ex, input fwd_t mem);
        logic hit_ex;
        logic hit_mem;
        hit_ex  = (addr != '0) && ex.en  && (ex.rd  == addr);
        hit_mem = (addr != '0) && mem.en && (mem.rd == addr);
        return hit_ex ? ex.data : (hit_mem ? mem.data : rf_data);
    endfunction

    assign insn    = fd_i.insn;
    assign rd_on_b = insn.opcode inside {op_sw, op_bne, op_blt};  // these read rd on port b

    assign raddr_a_o = insn.rs;
    assign raddr_b_o = rd_on_b ? insn.rd : insn.rt;

    // compare against the address actually driven, not the raw field
    assign op_a = fwd_pick(raddr_a_o, rdata_a_i, ex_fwd_i, mem_fwd_i);
    assign op_b = fwd_pick(raddr_b_o, rdata_b_i, ex_fwd_i, mem_fwd_i);

    always_ff @(posedge clock) begin
        dx_q.pc <= fd_i.pc;
        dx_q.a  <= op_a;
        dx_q.b  <= op_b;
        if (!rst_n_i) begin
            dx_q.insn <= nop_insn;
        end else begin
            dx_q.insn <= branch_taken_i ? nop_insn : insn;  // second slot behind a taken branch
        end
    end

    assign dx_o = dx_q;

endmodule

/* hdl/execute_stage.sv */
module execute_stage import cpu_pkg::*; (
    input  logic    clock,
    input  logic    rst_n_i,
    input  dx_reg_t dx_i,
    output logic    branch_taken_o,
    output word_t   branch_target_o,
    output fwd_t    ex_fwd_o,
    output xm_reg_t xm_o
);

    insn_t   insn;
    logic    is_bne;
    logic    is_blt;
    logic    is_branch;
    logic    use_imm;                     // addi, lw, sw
    word_t   imm;
    word_t   alu_a;
    word_t   alu_b;
    alu_op_e alu_op;
    word_t   alu_result;
    logic    ne;
    logic    lt;
    xm_reg_t xm_q;

    assign insn      = dx_i.insn;
    assign is_bne    = (insn.opcode == op_bne);
    assign is_blt    = (insn.opcode == op_blt);
    assign is_branch = is_bne || is_blt;
    assign use_imm   = insn.opcode inside {op_addi, op_lw, op_sw};
    assign imm       = {{(32 - imm_w){dx_i.insn[imm_w-1]}}, dx_i.insn[imm_w-1:0]};

    // branches compare rd (in b) against rs (in a)
    assign alu_a  = is_branch ? dx_i.b : dx_i.a;
    assign alu_b  = is_branch ? dx_i.a : (use_imm ? imm : dx_i.b);
    assign alu_op = is_branch ? alu_sub : (use_imm ? alu_add : insn.alu_op);

    alu i_alu (
        .a_i        (alu_a),
        .b_i        (alu_b),
        .op_i       (alu_op),
        .shamt_i    (insn.shamt),
        .result_o   (alu_result),
        .not_equal_o(ne),
        .less_than_o(lt)
    );

    assign branch_taken_o  = (is_bne && ne) || (is_blt && lt);
    assign branch_target_o = dx_i.pc + 32'd1 + imm;

    // lw is left out on purpose, its data only exists after memory
    assign ex_fwd_o.en   = insn.opcode inside {op_rtype, op_addi};
    assign ex_fwd_o.rd   = insn.rd;
    assign ex_fwd_o.data = alu_result;

    always_ff @(posedge clock) begin
        xm_q.result     <= alu_result;
        xm_q.store_data <= dx_i.b;              // rd value for sw
        if (!rst_n_i) begin
            xm_q.insn <= nop_insn;
        end else begin
            xm_q.insn <= insn;                  // a taken branch still moves on itself
        end
    end

    assign xm_o = xm_q;

    a_branch_kind: assert property (@(posedge clock) disable iff (!rst_n_i)
        branch_taken_o |=> xm_q.insn.opcode inside {op_bne, op_blt});

endmodule

/* hdl/memory_writeback.sv */
module memory_writeback import cpu_pkg::*; (
    input  logic      clock,
    input  logic      rst_n_i,
    input  xm_reg_t   xm_i,
    input  word_t     q_dmem_i,
    output word_t     address_dmem_o,
    output word_t     data_o,
    output logic      wren_o,
    output fwd_t      mem_fwd_o,
    output logic      reg_we_o,
    output reg_addr_t reg_waddr_o,
    output word_t     reg_wdata_o
);

    mw_reg_t mw_q;
    logic    mw_is_lw;

    // data memory is driven straight from the xm register
    assign address_dmem_o = xm_i.result;
    assign data_o         = xm_i.store_data;
    assign wren_o         = (xm_i.insn.opcode == op_sw);

    assign mem_fwd_o.en   = xm_i.insn.opcode inside {op_rtype, op_addi};  // not lw
    assign mem_fwd_o.rd   = xm_i.insn.rd;
    assign mem_fwd_o.data = xm_i.result;

    always_ff @(posedge clock) begin
        mw_q.result   <= xm_i.result;
        mw_q.mem_data <= q_dmem_i;              // load data, read combinationally
        if (!rst_n_i) begin
            mw_q.insn <= nop_insn;
        end else begin
            mw_q.insn <= xm_i.insn;
        end
    end

    assign mw_is_lw    = (mw_q.insn.opcode == op_lw);
    assign reg_we_o    = (mw_q.insn.opcode inside {op_rtype, op_addi, op_lw})
                         && (mw_q.insn.rd != '0);
    assign reg_waddr_o = mw_q.insn.rd;
    assign reg_wdata_o = mw_is_lw ? mw_q.mem_data : mw_q.result;

    // a store never turns into a register write one stage later
    a_store_no_write: assert property (@(posedge clock) disable iff (!rst_n_i)
        wren_o |=> !reg_we_o);

endmodule

/* hdl/processor.sv */
module processor import cpu_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic  clock,
    input  logic  rst_n_i,
    output word_t address_imem_o,        // to instruction memory
    input  word_t q_imem_i,
    output word_t address_dmem_o,        // to data memory
    output word_t data_o,
    output logic  wren_o,
    input  word_t q_dmem_i
);

    fd_reg_t   fd;
    dx_reg_t   dx;
    xm_reg_t   xm;
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    word_t     rdata_a;
    word_t     rdata_b;
    fwd_t      ex_fwd;
    fwd_t      mem_fwd;
    logic      branch_taken;             // squash and redirect, from execute
    word_t     branch_target;
    logic      reg_we;
    reg_addr_t reg_waddr;
    word_t     reg_wdata;

    fetch_stage #(
        .reset_pc(reset_pc)
    ) i_fetch_stage (
        .clock          (clock),
        .rst_n_i        (rst_n_i),
        .q_imem_i       (q_imem_i),
        .branch_taken_i (branch_taken),
        .branch_target_i(branch_target),
        .address_imem_o (address_imem_o),
        .fd_o           (fd)
    );

    regfile i_regfile (
        .clock    (clock),
        .rst_n_i  (rst_n_i),
        .we_i     (reg_we),
        .waddr_i  (reg_waddr),
        .wdata_i  (reg_wdata),
        .raddr_a_i(raddr_a),
        .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a),
        .rdata_b_o(rdata_b)
    );

    decode_stage i_decode_stage (
        .clock         (clock),
        .rst_n_i       (rst_n_i),
        .fd_i          (fd),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .ex_fwd_i      (ex_fwd),
        .mem_fwd_i     (mem_fwd),
        .branch_taken_i(branch_taken),
        .raddr_a_o     (raddr_a),
        .raddr_b_o     (raddr_b),
        .dx_o          (dx)
    );

    execute_stage i_execute_stage (
        .clock          (clock),
        .rst_n_i        (rst_n_i),
        .dx_i           (dx),
        .branch_taken_o (branch_taken),
        .branch_target_o(branch_target),
        .ex_fwd_o       (ex_fwd),
        .xm_o           (xm)
    );

    memory_writeback i_memory_writeback (
        .clock         (clock),
        .rst_n_i       (rst_n_i),
        .xm_i          (xm),
        .q_dmem_i      (q_dmem_i),
        .address_dmem_o(address_dmem_o),
        .data_o        (data_o),
        .wren_o        (wren_o),
        .mem_fwd_o     (mem_fwd),
        .reg_we_o      (reg_we),
        .reg_waddr_o   (reg_waddr),
        .reg_wdata_o   (reg_wdata)
    );

endmodule

/* tb/clock_gen.sv */
module clock_gen #(
    parameter int half_period  = 4,          // full period of 8
    parameter int reset_cycles = 16
) (
    output logic clock_o,
    output logic rst_n_o
);

    initial begin
        clock_o = 1'b0;
        forever #(half_period) clock_o = ~clock_o;
    end

    // reset is held low for reset_cycles rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clock_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* tb/tb_processor.sv */
module tb_processor import cpu_pkg::*; ();

    localparam word_t reset_pc   = '0;
    localparam int    wait_limit = 200;          // cycles a program may take

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic   clock;
    logic   rst_n;
    word_t  address_imem;
    word_t  q_imem;
    word_t  address_dmem;
    word_t  data_out;
    logic   wren;
    word_t  q_dmem;

    word_t  imem [1024] = '{default: '0};        // zero word is a nop
    word_t  dmem [256]  = '{default: '0};
    word_t  prog [$];                            // program being assembled
    store_t expect_q [$];                        // stores still to come, in order
    int     park;                                // two-word j loop the cpu idles in
    int     next_base;

    clock_gen i_clock_gen (
        .clock_o(clock),
        .rst_n_o(rst_n)
    );

    processor #(
        .reset_pc(reset_pc)
    ) i_processor (
        .clock         (clock),
        .rst_n_i       (rst_n),
        .address_imem_o(address_imem),
        .q_imem_i      (q_imem),
        .address_dmem_o(address_dmem),
        .data_o        (data_out),
        .wren_o        (wren),
        .q_dmem_i      (q_dmem)
    );

    assign q_imem = imem[address_imem[9:0]];     // both memories read combinationally
    assign q_dmem = dmem[address_dmem[7:0]];

    function automatic word_t r_insn(input alu_op_e fn, input reg_addr_t rd,
                                     input reg_addr_t rs, input reg_addr_t rt,
                                     input logic [4:0] sh);
        return {op_rtype, rd, rs, rt, sh, fn, 2'b00};
    endfunction

    function automatic word_t i_insn(input opcode_e op, input reg_addr_t rd,
                                     input reg_addr_t rs, input word_t imm);
        return {op, rd, rs, imm[16:0]};          // low 17 bits hold the immediate
    endfunction

    function automatic word_t j_insn(input int target);
        return {op_j, 27'(target)};
    endfunction

    // 16 random bits sign-extended, always fits the 17-bit immediate
    function automatic word_t rand_imm();
        logic [15:0] r;
        r = 16'($urandom);
        return {{16{r[15]}}, r};
    endfunction

    task automatic report_mismatch(input string sig, input word_t got, input word_t want);
        $display("error at %0t: %s = %h, expected %h", $time, sig, got, want);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string what);
        $display("%0t: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        expect_q.push_back({addr, data});
    endtask

    // every store leaving the cpu must be the next one expected
    always @(posedge clock) begin
        store_t want;
        if (rst_n && wren) begin
            dmem[address_dmem[7:0]] <= data_out;
            assert (expect_q.size() != 0)
                else abort_run($sformatf("unexpected store of %h to %h", data_out, address_dmem));
            if (expect_q.size() != 0) begin
                want = expect_q.pop_front();
                assert (address_dmem == want.addr)
                    else report_mismatch("address_dmem_o", address_dmem, want.addr);
                assert (data_out == want.data)
                    else report_mismatch("data_o", data_out, want.data);
            end
        end
    end

    // places prog in a fresh region, then steers the old park loop into it
    task automatic run_program(input string name);
        int         base;
        int         cycles;
        logic [9:0] slot;
        base = next_base;
        foreach (prog[i]) begin
            slot       = 10'(base + i);
            imem[slot] = prog[i];
        end
        imem[10'(base + prog.size())]     = j_insn(base + prog.size() + 1);  // new park pair
        imem[10'(base + prog.size() + 1)] = j_insn(base + prog.size());
        @(negedge clock);                                // fetch sees a settled word
        imem[10'(park)]     = j_insn(base);
        imem[10'(park + 1)] = j_insn(base);
        park      = base + prog.size();
        next_base = park + 4;
        cycles    = 0;
        while (expect_q.size() != 0 && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        assert (expect_q.size() == 0)
            else abort_run($sformatf("timeout in %s test, %0d stores never came",
                                     name, expect_q.size()));
        repeat (6) @(negedge clock);                     // tail drains into the park loop
        prog.delete();
    endtask

    task automatic check_idle();
        assert (wren == 1'b0) else report_mismatch("wren_o", 32'(wren), 32'd0);
        assert (address_imem == reset_pc)
            else report_mismatch("address_imem_o", address_imem, reset_pc);
    endtask

    task automatic check_reset();
        int cycles;
        cycles = 0;
        @(negedge clock);                                // pc loads at the first edge
        while (!rst_n && cycles < 40) begin
            check_idle();
            @(negedge clock);
            cycles++;
        end
        assert (rst_n) else abort_run("reset was never released");
        check_idle();                                    // first cycle out of reset
    endtask

    task automatic alu_test();
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        a  = rand_imm();
        b  = rand_imm();
        sh = 5'($urandom_range(1, 31));
        prog.push_back(i_insn(op_addi, 1, 0, a));
        prog.push_back(i_insn(op_addi, 2, 0, b));
        repeat (3) prog.push_back(32'd0);               // nops
        prog.push_back(r_insn(alu_add, 3, 1, 2, 0));
        prog.push_back(i_insn(op_sw, 3, 0, 'h40));
        prog.push_back(r_insn(alu_sub, 4, 1, 2, 0));
        prog.push_back(i_insn(op_sw, 4, 0, 'h41));
        prog.push_back(r_insn(alu_and, 5, 1, 2, 0));
        prog.push_back(i_insn(op_sw, 5, 0, 'h42));
        prog.push_back(r_insn(alu_or, 6, 1, 2, 0));
        prog.push_back(i_insn(op_sw, 6, 0, 'h43));
        prog.push_back(r_insn(alu_sll, 7, 1, 0, sh));   // shifts work on rs
        prog.push_back(i_insn(op_sw, 7, 0, 'h44));
        prog.push_back(r_insn(alu_sra, 8, 1, 0, sh));
        prog.push_back(i_insn(op_sw, 8, 0, 'h45));
        expect_store('h40, a + b);
        expect_store('h41, a - b);
        expect_store('h42, a & b);
        expect_store('h43, a | b);
        expect_store('h44, a << sh);
        // logical shift, then copies of the sign bit fill the vacated top bits
        expect_store('h45, a[31] ? ((a >> sh) | ~(32'hffff_ffff >> sh)) : (a >> sh));
        run_program("alu");
    endtask

    task automatic forwarding_test();
        word_t a;
        word_t s2;
        word_t s4;
        a  = rand_imm();
        s2 = a + rand_imm();
        s4 = s2 + a + 32'd5;
        prog.push_back(i_insn(op_addi, 1, 0, a));
        prog.push_back(i_insn(op_addi, 2, 1, s2 - a));  // r1 from execute
        prog.push_back(r_insn(alu_add, 3, 2, 1, 0));    // r2 from execute, r1 from memory
        prog.push_back(i_insn(op_addi, 4, 3, 5));
        prog.push_back(i_insn(op_sw, 4, 0, 'h50));      // store data bypassed
        prog.push_back(r_insn(alu_add, 5, 4, 2, 0));
        prog.push_back(i_insn(op_addi, 6, 0, 'h53));
        prog.push_back(i_insn(op_sw, 5, 6, 0));         // address from execute
        expect_store('h50, s4);
        expect_store('h53, s4 + s2);
        run_program("forwarding");
    endtask

    task automatic load_test();
        logic [15:0] hi;
        logic [15:0] lo;
        word_t       k;
        hi = 16'($urandom);
        lo = 16'($urandom);
        k  = rand_imm();
        prog.push_back(i_insn(op_addi, 1, 0, {16'd0, hi}));
        prog.push_back(r_insn(alu_sll, 1, 1, 0, 16));
        prog.push_back(i_insn(op_addi, 2, 0, {16'd0, lo}));
        prog.push_back(r_insn(alu_or, 1, 1, 2, 0));      // r1 = full random word
        prog.push_back(i_insn(op_sw, 1, 0, 'h60));
        prog.push_back(i_insn(op_lw, 3, 0, 'h60));
        prog.push_back(i_insn(op_addi, 4, 0, k));
        prog.push_back(32'd0);
        prog.push_back(r_insn(alu_add, 5, 3, 4, 0));    // third slot after the lw
        prog.push_back(i_insn(op_sw, 5, 0, 'h61));
        expect_store('h60, {hi, lo});
        expect_store('h61, {hi, lo} + k);
        run_program("load");
    endtask

    task automatic branch_test(input opcode_e op, input logic want_taken);
        word_t x;
        word_t y;
        word_t rd_val;
        word_t rs_val;
        logic  taken;
        x = rand_imm();
        y = rand_imm();
        if (x == y) y = x + 32'd1;
        if (op == op_bne && !want_taken) y = x;
        // order the pair so the signed compare goes the wanted way
        if (($signed(x) < $signed(y)) == want_taken) begin
            rd_val = x;
            rs_val = y;
        end else begin
            rd_val = y;
            rs_val = x;
        end
        taken = (op == op_bne) ? (rd_val != rs_val) : ($signed(rd_val) < $signed(rs_val));
        prog.push_back(i_insn(op_addi, 1, 0, rd_val));
        prog.push_back(i_insn(op_addi, 2, 0, rs_val));
        prog.push_back(i_insn(op, 1, 2, 3));             // target is pc + 4
        prog.push_back(i_insn(op_sw, 1, 0, 'h70));       // squashed when taken
        prog.push_back(i_insn(op_sw, 2, 0, 'h71));
        prog.push_back(32'd0);
        prog.push_back(i_insn(op_sw, 2, 0, 'h72));
        if (!taken) begin
            expect_store('h70, rd_val);
            expect_store('h71, rs_val);
        end
        expect_store('h72, rs_val);
        run_program(taken ? "taken branch" : "untaken branch");
    endtask

    task automatic jump_test();
        word_t v;
        v = rand_imm();
        prog.push_back(i_insn(op_addi, 1, 0, v));
        prog.push_back(j_insn(next_base + 3));
        prog.push_back(i_insn(op_sw, 1, 0, 'h78));       // never fetched
        prog.push_back(i_insn(op_sw, 1, 0, 'h79));
        expect_store('h79, v);
        run_program("jump");
    endtask

    initial begin
        void'($urandom(52044));
        imem[0]   = j_insn(1);                           // idle loop at reset_pc
        imem[1]   = j_insn(0);
        park      = 0;
        next_base = 16;
        check_reset();
        alu_test();
        forwarding_test();
        load_test();
        branch_test(op_bne, 1'b1);
        branch_test(op_bne, 1'b0);
        branch_test(op_blt, 1'b1);
        branch_test(op_blt, 1'b0);
        jump_test();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* tb.f */
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/fetch_stage.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_writeback.sv
hdl/processor.sv
tb/clock_gen.sv
tb/tb_processor.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module tb_processor -f tb.f -o tb_sim &&
    ./obj_dir/tb_sim ||
    { echo "build or simulation failed" >&2; exit 1; }
